/* johnson_cfg.svh */
`ifndef JOHNSON_CFG_SVH
`define JOHNSON_CFG_SVH

// --------------------
// Counter geometry
// --------------------

// Bits in the Johnson code word
// The ring has twice this many states
`define JOHNSON_WIDTH 8

// --------------------
// Testbench run limits
// --------------------

// Upper bound on stimulus table rows
`define TB_TABLE_ROWS 24
// Longest row is a full ring walk plus a few settle cycles
`define TB_ROW_MAX_STEPS (2 * `JOHNSON_WIDTH + 4)
// Cycles spent in reset at start of run
`define TB_RESET_CYCLES 5
// Hard stop for the whole run with some margin on top
`define TB_MAX_CYCLES (`TB_TABLE_ROWS * `TB_ROW_MAX_STEPS + `TB_RESET_CYCLES + 50)

`endif

/* johnson_pkg.sv */
`include "johnson_cfg.svh"

package johnson_pkg;

        // --------------------
        // Shared types
        // --------------------

        // One Johnson code word
        typedef logic [`JOHNSON_WIDTH-1:0] code_t;

        // Bit position inside a code word
        typedef logic [$clog2(`JOHNSON_WIDTH)-1:0] index_t;

        // Decoded count from 0 to 2*W-1
        typedef logic [$clog2(2 * `JOHNSON_WIDTH)-1:0] bin_t;

endpackage : johnson_pkg

/* lead_trail_if.sv */
`timescale 1ns/1ns

interface lead_trail_if;

        // Index of highest and lowest set bit
        johnson_pkg::index_t leadingone;
        johnson_pkg::index_t trailingone;

        // Same positions as one-hot words
        // Both stay zero when data is zero
        johnson_pkg::code_t  leadingone_vector;
        johnson_pkg::code_t  trailingone_vector;

        // Whole-word flags
        logic                all_zeroes;
        logic                all_ones;
        // At least one bit set
        logic                valid;

        // Producer side
        modport detector (
                output leadingone, trailingone,
                output leadingone_vector, trailingone_vector,
                output all_zeroes, all_ones, valid
        );

        // Consumer side
        modport user (
                input leadingone, trailingone,
                input leadingone_vector, trailingone_vector,
                input all_zeroes, all_ones, valid
        );

endinterface : lead_trail_if

/* find_first_set.sv */
`timescale 1ns/1ns

module find_first_set #(
        parameter int WIDTH = 8
) (
        input  logic [WIDTH-1:0]         data,
        output logic [$clog2(WIDTH)-1:0] index
);

        localparam int N = $clog2(WIDTH);

        // --------------------
        // Priority scan from bit 0 upward
        // --------------------
        always_comb begin
                logic found;

                // No bit set gives index 0
                index = '0;
                found = 1'b0;
                for (int i = 0; i < WIDTH; i++) begin
                        // First hit wins and later bits are ignored
                        if (data[i] && !found) begin
                                index = N'(i);
                                found = 1'b1;
                        end
                end
        end

endmodule : find_first_set

/* find_last_set.sv */
`timescale 1ns/1ns

module find_last_set #(
        parameter int WIDTH = 8
) (
        input  logic [WIDTH-1:0]         data,
        output logic [$clog2(WIDTH)-1:0] index
);

        localparam int N = $clog2(WIDTH);

        // --------------------
        // Priority scan from the top bit downward
        // --------------------
        always_comb begin
                logic found;

                // Empty word reports position 0
                index = '0;
                found = 1'b0;
                for (int i = WIDTH - 1; i >= 0; i--) begin
                        // Keep the highest set bit only
                        if (data[i] && !found) begin
                                index = N'(i);
                                found = 1'b1;
                        end
                end
        end

endmodule : find_last_set

/* leading_one_trailing_one.sv */
`timescale 1ns/1ns

module leading_one_trailing_one (
        input  johnson_pkg::code_t data,
        lead_trail_if.detector     res
);

        localparam int W = $bits(johnson_pkg::code_t);

        // --------------------
        // Index finders
        // --------------------

        // Highest set bit
        find_last_set #(
                .WIDTH (W)
        ) u_find_last_set (
                .data  (data),
                .index (res.leadingone)
        );

        // Lowest set bit
        find_first_set #(
                .WIDTH (W)
        ) u_find_first_set (
                .data  (data),
                .index (res.trailingone)
        );

        // --------------------
        // One-hot vectors
        // --------------------
        always_comb begin
                res.leadingone_vector  = '0;
                res.trailingone_vector = '0;
                // Finders report 0 on empty input so that case is masked out
                if (|data) begin
                        res.leadingone_vector[res.leadingone]   = 1'b1;
                        res.trailingone_vector[res.trailingone] = 1'b1;
                end
        end

        // Word flags
        assign res.all_ones   = &data;
        assign res.all_zeroes = ~(|data);
        assign res.valid      = |data;

        // Lead vector sits on the top set bit and trail vector on the bottom one
        always_comb begin
                if (res.valid) begin
                        a_vectors_on_ends : assert final (
                                |(data & res.leadingone_vector) &&
                                |(data & res.trailingone_vector) &&
                                ((data & (res.trailingone_vector - 1'b1)) == '0) &&
                                ({1'b0, data} < ({1'b0, res.leadingone_vector} << 1)))
                        else $error("detector vectors miss the end bits of data %h", data);
                end
        end

endmodule : leading_one_trailing_one

/* johnson_counter.sv */
`timescale 1ns/1ns

module johnson_counter (
        input  logic               clk,
        input  logic               rst_n,
        input  logic               step,
        input  logic               load,
        input  johnson_pkg::code_t load_code,
        output johnson_pkg::code_t code
);

        localparam int W = $bits(johnson_pkg::code_t);

        // --------------------
        // State register
        // --------------------
        always_ff @(posedge clk) begin
                if (!rst_n) begin
                        // All zeroes is state 0 of the ring
                        code <= '0;
                end else if (load) begin
                        // Load beats step and accepts any pattern
                        code <= load_code;
                end else if (step) begin
                        // Shift left with the inverted top bit wrapping into bit 0
                        code <= {code[W-2:0], ~code[W-1]};
                end
        end

        // Undoing one step alone must give back the previous code
        property p_step_shift;
                @(posedge clk) disable iff (!rst_n)
                (step && !load) |=> ($past(code) == {~code[0], code[W-1:1]});
        endproperty

        a_step_shift : assert property (p_step_shift)
        else $error("step did not shift code, got %h", code);

endmodule : johnson_counter

/* grayj2bin.sv */
`timescale 1ns/1ns

module grayj2bin (
        input  logic               clk,
        input  logic               rst_n,
        input  johnson_pkg::code_t code,
        lead_trail_if.user         res,
        output johnson_pkg::bin_t  binary,
        output logic               code_error
);

        localparam int W = $bits(johnson_pkg::code_t);

        johnson_pkg::bin_t  bin_next;
        johnson_pkg::code_t run_mask;
        logic               legal;

        // --------------------
        // Decode
        // --------------------
        always_comb begin
                if (res.all_zeroes) begin
                        bin_next = '0;
                end else if (!code[W-1]) begin
                        // Filling phase where ones grow from bit 0
                        bin_next = johnson_pkg::bin_t'(res.leadingone) + johnson_pkg::bin_t'(1);
                end else if (res.all_ones) begin
                        bin_next = johnson_pkg::bin_t'(W);
                end else begin
                        // Draining phase where zeroes grow from bit 0
                        bin_next = johnson_pkg::bin_t'(W) +
                                   johnson_pkg::bin_t'(res.trailingone);
                end
        end

        // --------------------
        // Legality
        // --------------------

        // Contiguous ones from trailing to leading bit
        // A top-bit lead shifts out and the wrapping subtract still gives the run
        assign run_mask = (res.leadingone_vector << 1) - res.trailingone_vector;

        // Either empty or a single run anchored at one end of the word
        assign legal = res.all_zeroes ||
                       ((code == run_mask) && (code[0] || code[W-1]));

        // Outputs land one cycle after the code
        always_ff @(posedge clk) begin
                if (!rst_n) begin
                        binary     <= '0;
                        code_error <= 1'b0;
                end else begin
                        binary     <= bin_next;
                        code_error <= ~legal;
                end
        end

        // Detector results must describe the same code this decoder sees
        a_detect_matches_code : assert property (
                @(posedge clk) disable iff (!rst_n)
                (res.valid == (code != '0)) &&
                (!res.valid || (code[res.leadingone] && code[res.trailingone])))
        else $error("detector results do not match code %h", code);

endmodule : grayj2bin

/* johnson_decode_top.sv */
`timescale 1ns/1ns

module johnson_decode_top (
        input  logic               clk,
        input  logic               rst_n,
        input  logic               step,
        input  logic               load,
        input  johnson_pkg::code_t load_code,
        output johnson_pkg::code_t code,
        output johnson_pkg::bin_t  binary,
        output logic               code_error
);

        // Detector results shared with the decoder
        lead_trail_if lt_if ();

        // --------------------
        // Counter
        // --------------------
        johnson_counter u_counter (
                .clk       (clk),
                .rst_n     (rst_n),
                .step      (step),
                .load      (load),
                .load_code (load_code),
                .code      (code)
        );

        // Leading and trailing one on the live code
        leading_one_trailing_one u_detect (
                .data (code),
                .res  (lt_if.detector)
        );

        // --------------------
        // Decoder with one register stage
        // --------------------
        grayj2bin u_decode (
                .clk        (clk),
                .rst_n      (rst_n),
                .code       (code),
                .res        (lt_if.user),
                .binary     (binary),
                .code_error (code_error)
        );

endmodule : johnson_decode_top

/* tb_clk_gen.sv */
`timescale 1ns/1ns

module tb_clk_gen #(
        parameter int PERIOD       = 100,
        parameter int RESET_CYCLES = 5
) (
        output logic clk,
        output logic rst_n
);

        // Free-running clock at 50 ns high and 50 ns low
        initial begin
                clk = 1'b0;
                forever #(PERIOD / 2) clk = ~clk;
        end

        // Reset held low for a fixed count of edges and released just after an edge
        initial begin
                rst_n = 1'b0;
                repeat (RESET_CYCLES) @(posedge clk);
                #5 rst_n = 1'b1;
        end

endmodule : tb_clk_gen

/* tb_johnson_decode.sv */
`timescale 1ns/1ns
`include "johnson_cfg.svh"

module tb_johnson_decode;

        localparam int W = `JOHNSON_WIDTH;

        typedef enum int {OP_RESET, OP_STEP, OP_HOLD, OP_LOAD, OP_LOAD_STEP, OP_RAND} op_e;

        typedef struct packed {
                op_e                op;
                int                 cycles;
                johnson_pkg::code_t value;
        } row_t;

        logic clk, rst_n_gen, rst_n_tb, rst_n, step, load;
        johnson_pkg::code_t load_code, code;
        johnson_pkg::bin_t  binary;
        logic               code_error;

        // Reference model state for the DUT outputs
        johnson_pkg::code_t m_code;
        johnson_pkg::bin_t  m_bin;
        logic               m_err;

        row_t        rows[$];
        logic [31:0] lfsr_state = 32'h3852;
        int          err_count, rows_passed, rows_failed, cycle_count;

        // Row resets come on top of the power-on reset
        assign rst_n = rst_n_gen & rst_n_tb;

        tb_clk_gen #(.PERIOD(100), .RESET_CYCLES(`TB_RESET_CYCLES)) u_clk_gen (
                .clk   (clk),
                .rst_n (rst_n_gen)
        );

        johnson_decode_top uut (
                .clk        (clk),
                .rst_n      (rst_n),
                .step       (step),
                .load       (load),
                .load_code  (load_code),
                .code       (code),
                .binary     (binary),
                .code_error (code_error)
        );

        // --------------------
        // Reference model
        // --------------------

        // Value from the fill/drain position of the run
        function automatic johnson_pkg::bin_t decode_model(input johnson_pkg::code_t c);
                int lead;
                int trail;
                lead  = 0;
                trail = 0;
                for (int i = 0; i < W; i++) begin
                        if (c[i]) lead = i;
                end
                for (int i = W - 1; i >= 0; i--) begin
                        if (c[i]) trail = i;
                end
                if (c == '0) return '0;
                if (!c[W-1]) return johnson_pkg::bin_t'(lead + 1);
                if (&c) return johnson_pkg::bin_t'(W);
                return johnson_pkg::bin_t'(W + trail);
        endfunction

        // One run touching an end has at most one bit-to-bit change
        function automatic logic legal_model(input johnson_pkg::code_t c);
                int edges;
                edges = 0;
                for (int i = 0; i < W - 1; i++) begin
                        if (c[i] != c[i+1]) edges++;
                end
                return edges <= 1;
        endfunction

        // Fibonacci LFSR with taps 32 22 2 1
        function automatic logic [31:0] lfsr_next(input logic [31:0] s);
                return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
        endfunction

        task automatic draw_random_code(output johnson_pkg::code_t val);
                for (int i = 0; i < W; i++) begin
                        lfsr_state = lfsr_next(lfsr_state);
                        val[i]     = lfsr_state[0];
                end
        endtask

        function automatic row_t make_row(input op_e op, input int n, input johnson_pkg::code_t v);
                row_t r;
                r.op     = op;
                r.cycles = n;
                r.value  = v;
                return r;
        endfunction

        function automatic string op_label(input op_e op);
                case (op)
                        OP_RESET:     return "reset";
                        OP_STEP:      return "step";
                        OP_HOLD:      return "hold";
                        OP_LOAD:      return "load";
                        OP_LOAD_STEP: return "load+step";
                        default:      return "random load";
                endcase
        endfunction

        // --------------------
        // Compare tasks
        // --------------------
        task automatic check_code(input johnson_pkg::code_t exp, input johnson_pkg::code_t act);
                if (act !== exp) begin
                        $display("FAILED code expected %h got %h", exp, act);
                        err_count++;
                end
        endtask

        task automatic check_binary(input johnson_pkg::bin_t exp, input johnson_pkg::bin_t act);
                if (act !== exp) begin
                        $display("FAILED binary expected %h got %h", exp, act);
                        err_count++;
                end
        endtask

        task automatic check_error(input logic exp, input logic act);
                if (act !== exp) begin
                        $display("FAILED code_error expected %h got %h", exp, act);
                        err_count++;
                end
        endtask

        // Drive 5 ns after an edge and check 5 ns after the next one
        task automatic run_cycle(input logic rst_v, input logic step_v, input logic load_v,
                                 input johnson_pkg::code_t val);
                johnson_pkg::code_t old_code;
                old_code  = m_code;
                rst_n_tb  = rst_v;
                step      = step_v;
                load      = load_v;
                load_code = val;
                @(posedge clk);
                #5;
                if (!rst_v) begin
                        m_code = '0;
                        m_bin  = '0;
                        m_err  = 1'b0;
                end else begin
                        // Decoder registers the code that stood before the edge
                        m_bin = decode_model(old_code);
                        m_err = !legal_model(old_code);
                        if (load_v) m_code = val;
                        else if (step_v) m_code = (old_code << 1) |
                                                  johnson_pkg::code_t'(!old_code[W-1]);
                end
                check_code(m_code, code);
                check_binary(m_bin, binary);
                check_error(m_err, code_error);
        endtask

        // Hard stop in case the run stalls
        always @(posedge clk) begin
                cycle_count <= cycle_count + 1;
                if (cycle_count >= `TB_MAX_CYCLES) begin
                        $display("Timeout: run went past %0d cycles", `TB_MAX_CYCLES);
                        $display("STATUS: FAIL");
                        $finish;
                end
        end

        // --------------------
        // Stimulus table and main loop
        // --------------------
        initial begin
                johnson_pkg::code_t val;
                int                 errs_before;
                rst_n_tb    = 1'b1;
                step        = 1'b0;
                load        = 1'b0;
                load_code   = '0;
                m_code      = '0;
                m_bin       = '0;
                m_err       = 1'b0;
                err_count   = 0;
                rows_passed = 0;
                rows_failed = 0;
                cycle_count = 0;

                rows.push_back(make_row(OP_RESET, 2, 8'h00));
                // Full ring and wrap back to zero
                rows.push_back(make_row(OP_STEP, 18, 8'h00));
                rows.push_back(make_row(OP_HOLD, 3, 8'h00));
                rows.push_back(make_row(OP_LOAD, 2, 8'hff));
                rows.push_back(make_row(OP_HOLD, 2, 8'h00));
                rows.push_back(make_row(OP_LOAD, 2, 8'hf0));
                rows.push_back(make_row(OP_LOAD_STEP, 2, 8'h0f));
                // Split run and lone middle bit
                rows.push_back(make_row(OP_LOAD, 2, 8'h66));
                rows.push_back(make_row(OP_LOAD, 2, 8'h10));
                rows.push_back(make_row(OP_STEP, 10, 8'h00));
                rows.push_back(make_row(OP_RAND, 2, 8'h00));
                rows.push_back(make_row(OP_RAND, 2, 8'h00));
                rows.push_back(make_row(OP_STEP, 5, 8'h00));
                rows.push_back(make_row(OP_RAND, 2, 8'h00));
                // Both ends set
                rows.push_back(make_row(OP_LOAD, 2, 8'h81));
                rows.push_back(make_row(OP_STEP, 4, 8'h00));
                rows.push_back(make_row(OP_LOAD, 2, 8'h07));
                rows.push_back(make_row(OP_RESET, 2, 8'h00));
                rows.push_back(make_row(OP_STEP, 3, 8'h00));

                // Power-on reset leaves everything at zero
                @(posedge rst_n_gen);
                errs_before = err_count;
                check_code('0, code);
                check_binary('0, binary);
                check_error(1'b0, code_error);
                if (err_count == errs_before) rows_passed++;
                else rows_failed++;
                $display("power-on reset: %s", (err_count == errs_before) ? "ok" : "mismatch");

                foreach (rows[i]) begin
                        errs_before = err_count;
                        val         = rows[i].value;
                        if (rows[i].op == OP_RAND) draw_random_code(val);
                        case (rows[i].op)
                                OP_RESET: repeat (rows[i].cycles) run_cycle(1'b0, 1'b0, 1'b0, '0);
                                OP_STEP:  repeat (rows[i].cycles) run_cycle(1'b1, 1'b1, 1'b0, '0);
                                OP_HOLD:  repeat (rows[i].cycles) run_cycle(1'b1, 1'b0, 1'b0, '0);
                                default: begin
                                        // Load strobe with step too for the priority row
                                        run_cycle(1'b1, rows[i].op == OP_LOAD_STEP, 1'b1, val);
                                        repeat (rows[i].cycles - 1) run_cycle(1'b1, 1'b0, 1'b0, '0);
                                end
                        endcase
                        if (err_count == errs_before) rows_passed++;
                        else rows_failed++;
                        $display("row %0d %s %h x%0d: %s", i, op_label(rows[i].op), val,
                                 rows[i].cycles, (err_count == errs_before) ? "ok" : "mismatch");
                end

                $display("tests passed %0d, failed %0d", rows_passed, rows_failed);
                if (rows_failed == 0) begin
                        $display("STATUS: PASS");
                end else begin
                        $display("STATUS: FAIL");
                end
                $finish;
        end

endmodule : tb_johnson_decode

/* flist.f */
+incdir+.
johnson_pkg.sv
lead_trail_if.sv
find_first_set.sv
find_last_set.sv
leading_one_trailing_one.sv
johnson_counter.sv
grayj2bin.sv
johnson_decode_top.sv
tb_clk_gen.sv
tb_johnson_decode.sv

/* Bender.yml */
package:
  name: johnson_decode

sources:
  - include_dirs:
      - .
    files:
      - johnson_pkg.sv
      - lead_trail_if.sv
      - find_first_set.sv
      - find_last_set.sv
      - leading_one_trailing_one.sv
      - johnson_counter.sv
      - grayj2bin.sv
      - johnson_decode_top.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - tb_clk_gen.sv
      - tb_johnson_decode.sv
